//--- source/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // data word and bank geometry
  localparam int DATA_W    = 16;
  localparam int NUM_BANKS = 4;
  localparam int BANK_W    = 2;
  localparam int NUM_ROWS  = 16;
  localparam int ROW_W     = 4;

  // the low address bits pick the bank and the upper bits pick the row
  localparam int ADDR_W = BANK_W + ROW_W;

  localparam int FIFO_DEPTH = 2;
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);

  typedef struct packed {
    logic              rd;
    logic [ADDR_W-1:0] rd_addr;
    logic              wr;
    logic [ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;
  } mem_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
  } mem_resp_t;

  // one single-port bank operation in one cycle
  typedef struct packed {
    logic              rd;
    logic              wr;
    logic [ROW_W-1:0]  row;
    logic [DATA_W-1:0] data;
  } bank_op_t;

  // bank whose row currently lives in the spare bank
  typedef struct packed {
    logic              valid;
    logic [BANK_W-1:0] bank;
  } map_entry_t;

endpackage

`default_nettype wire

//--- source/stream_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 2
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       push_valid,
  input  payload_t                   push_data,
  output logic                       push_ready,
  output logic                       pop_valid,
  output payload_t                   pop_data,
  input  logic                       pop_ready,
  output logic [$clog2(DEPTH+1)-1:0] count
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t         buf_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_push;
  logic             do_pop;

  assign push_ready = (count != DEPTH);
  assign pop_valid  = (count != '0);
  assign pop_data   = buf_mem[rd_ptr];

  assign do_push = push_valid && push_ready;
  assign do_pop  = pop_valid && pop_ready;

  always_ff @(posedge clk) begin
    if (do_push) begin
      buf_mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_count_range: assert property (@(posedge clk) disable iff (rst) count <= DEPTH);

endmodule

`default_nettype wire

//--- source/bank_array.sv
`timescale 1ns/1ps
`default_nettype none

module bank_array import mem_pkg::*; (
  input  logic              clk,
  input  bank_op_t          bank_ops  [NUM_BANKS],
  output logic [DATA_W-1:0] bank_dout [NUM_BANKS]
);

  // each bank models a single-port array with one cycle of read latency
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    logic [DATA_W-1:0] mem [NUM_ROWS];

    always_ff @(posedge clk) begin
      if (bank_ops[b].wr) begin
        mem[bank_ops[b].row] <= bank_ops[b].data;
      end
    end

    // the output holds the last read word until the next read
    always_ff @(posedge clk) begin
      if (bank_ops[b].rd) begin
        bank_dout[b] <= mem[bank_ops[b].row];
      end
    end

    // a single-port bank can take only one operation per cycle
    a_one_port: assert property (@(posedge clk) bank_ops[b].wr |-> !bank_ops[b].rd);
  end

endmodule

`default_nettype wire

//--- source/remap_table.sv
`timescale 1ns/1ps
`default_nettype none

module remap_table import mem_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              issue_valid,
  input  mem_req_t          issue_req,
  output bank_op_t          bank_ops [NUM_BANKS],
  output logic              spare_hit,
  output logic [DATA_W-1:0] spare_data
);

  map_entry_t        map_mem   [NUM_ROWS];
  logic [DATA_W-1:0] spare_mem [NUM_ROWS];

  logic [BANK_W-1:0] rd_bank;
  logic [BANK_W-1:0] wr_bank;
  logic [ROW_W-1:0]  rd_row;
  logic [ROW_W-1:0]  wr_row;
  map_entry_t        rd_entry;
  map_entry_t        wr_entry;
  logic              do_rd;
  logic              do_wr;
  logic              rd_spare;
  logic              wr_spare;
  logic              conflict;
  logic              evict;
  logic              to_spare;
  logic              home_wr;
  logic [DATA_W-1:0] evict_data;

  assign rd_bank = issue_req.rd_addr[BANK_W-1:0];
  assign rd_row  = issue_req.rd_addr[ADDR_W-1:BANK_W];
  assign wr_bank = issue_req.wr_addr[BANK_W-1:0];
  assign wr_row  = issue_req.wr_addr[ADDR_W-1:BANK_W];

  assign rd_entry = map_mem[rd_row];
  assign wr_entry = map_mem[wr_row];

  assign do_rd = issue_valid && issue_req.rd;
  assign do_wr = issue_valid && issue_req.wr;

  // the current copy of the addressed row sits in the spare bank
  assign rd_spare = rd_entry.valid && (rd_entry.bank == rd_bank);
  assign wr_spare = wr_entry.valid && (wr_entry.bank == wr_bank);

  // the read occupies the write's home bank, so the write moves aside
  assign conflict = do_wr && do_rd && !wr_spare && !rd_spare && (rd_bank == wr_bank);

  // the spare row belonged to another bank and goes back home
  assign evict      = conflict && wr_entry.valid;
  assign evict_data = spare_mem[wr_row];

  assign to_spare = do_wr && (wr_spare || conflict);
  assign home_wr  = do_wr && !to_spare;

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_op
    logic sel_rd;
    logic sel_wr;
    logic sel_wb;

    assign sel_rd = do_rd && !rd_spare && (rd_bank == BANK_W'(b));
    assign sel_wr = home_wr && (wr_bank == BANK_W'(b));
    assign sel_wb = evict && (wr_entry.bank == BANK_W'(b));

    assign bank_ops[b] = '{
      rd:   sel_rd,
      wr:   sel_wr || sel_wb,
      row:  sel_rd ? rd_row : wr_row,
      data: sel_wb ? evict_data : issue_req.wr_data
    };
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < NUM_ROWS; r++) begin
        map_mem[r] <= '0;
      end
    end else if (conflict) begin
      map_mem[wr_row] <= '{valid: 1'b1, bank: wr_bank};
    end
  end

  always_ff @(posedge clk) begin
    if (to_spare) begin
      spare_mem[wr_row] <= issue_req.wr_data;
    end
  end

  // spare reads are delayed to line up with the bank read latency
  always_ff @(posedge clk) begin
    if (rst) begin
      spare_hit <= 1'b0;
    end else begin
      spare_hit <= do_rd && rd_spare;
    end
  end

  always_ff @(posedge clk) begin
    spare_data <= spare_mem[rd_row];
  end

  a_wb_free_bank: assert property (@(posedge clk) disable iff (rst)
    (evict && do_rd) |-> (wr_entry.bank != rd_bank));

endmodule

`default_nettype wire

//--- source/access_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module access_ctrl import mem_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              req_valid,
  input  mem_req_t          req,
  output logic              req_ready,
  input  logic [CNT_W-1:0]  out_count,
  output logic              issue_valid,
  output mem_req_t          issue_req,
  input  logic              spare_hit,
  input  logic [DATA_W-1:0] spare_data,
  input  logic [DATA_W-1:0] bank_dout [NUM_BANKS],
  output logic              resp_valid,
  output mem_resp_t         resp
);

  logic              rd_pend;
  logic [BANK_W-1:0] rd_bank_q;
  logic [CNT_W:0]    used;

  // a slot in the output FIFO is reserved for every read in flight
  assign used      = {1'b0, out_count} + (CNT_W + 1)'(rd_pend);
  assign req_ready = (used < (CNT_W + 1)'(FIFO_DEPTH));

  assign issue_valid = req_valid && req_ready;
  assign issue_req   = req;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_pend <= 1'b0;
    end else begin
      rd_pend <= issue_valid && req.rd;
    end
  end

  always_ff @(posedge clk) begin
    rd_bank_q <= req.rd_addr[BANK_W-1:0];
  end

  // read data arrives one cycle after the issue, from spare or home bank
  assign resp_valid = rd_pend;
  assign resp       = '{data: spare_hit ? spare_data : bank_dout[rd_bank_q]};

endmodule

`default_nettype wire

//--- source/mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_top import mem_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      in_valid,
  input  mem_req_t  in_req,
  output logic      in_ready,
  output logic      out_valid,
  output mem_resp_t out_resp,
  input  logic      out_ready
);

  logic              req_valid;
  logic              req_ready;
  mem_req_t          req;
  logic              issue_valid;
  mem_req_t          issue_req;
  bank_op_t          bank_ops  [NUM_BANKS];
  logic [DATA_W-1:0] bank_dout [NUM_BANKS];
  logic              spare_hit;
  logic [DATA_W-1:0] spare_data;
  logic              resp_valid;
  logic              resp_ready;
  mem_resp_t         resp;
  logic [CNT_W-1:0]  out_count;

  stream_fifo #(
    .payload_t (mem_req_t),
    .DEPTH     (FIFO_DEPTH)
  ) req_fifo_inst (
    .clk        (clk),
    .rst        (rst),
    .push_valid (in_valid),
    .push_data  (in_req),
    .push_ready (in_ready),
    .pop_valid  (req_valid),
    .pop_data   (req),
    .pop_ready  (req_ready),
    .count      ()
  );

  access_ctrl access_ctrl_inst (
    .clk         (clk),
    .rst         (rst),
    .req_valid   (req_valid),
    .req         (req),
    .req_ready   (req_ready),
    .out_count   (out_count),
    .issue_valid (issue_valid),
    .issue_req   (issue_req),
    .spare_hit   (spare_hit),
    .spare_data  (spare_data),
    .bank_dout   (bank_dout),
    .resp_valid  (resp_valid),
    .resp        (resp)
  );

  remap_table remap_table_inst (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue_valid),
    .issue_req   (issue_req),
    .bank_ops    (bank_ops),
    .spare_hit   (spare_hit),
    .spare_data  (spare_data)
  );

  bank_array bank_array_inst (
    .clk       (clk),
    .bank_ops  (bank_ops),
    .bank_dout (bank_dout)
  );

  stream_fifo #(
    .payload_t (mem_resp_t),
    .DEPTH     (FIFO_DEPTH)
  ) resp_fifo_inst (
    .clk        (clk),
    .rst        (rst),
    .push_valid (resp_valid),
    .push_data  (resp),
    .push_ready (resp_ready),
    .pop_valid  (out_valid),
    .pop_data   (out_resp),
    .pop_ready  (out_ready),
    .count      (out_count)
  );

  // the credit check in access_ctrl must leave room for every response
  a_resp_room: assert property (@(posedge clk) disable iff (rst) resp_valid |-> resp_ready);

endmodule

`default_nettype wire

//--- test/mem_tb_table.svh
`ifndef MEM_TB_TABLE_SVH
`define MEM_TB_TABLE_SVH

  localparam int TABLE_LEN = 26;

  // columns are rd, rd_addr, wr, wr_addr, wr_data and the expected read word
  // an address is row * 4 + bank
  // the fill phase leaves 16'h5a00 + address everywhere
  localparam table_entry_t STIM_TABLE [TABLE_LEN] = '{
    // plain reads after the fill
    '{1'b1, 6'h00, 1'b0, 6'h00, 16'h0000, 16'h5a00},
    '{1'b1, 6'h2b, 1'b0, 6'h00, 16'h0000, 16'h5a2b},
    // a read in the same bank but another row moves the write into spare row 3
    '{1'b1, 6'h05, 1'b1, 6'h0d, 16'h1111, 16'h5a05},
    '{1'b1, 6'h0d, 1'b0, 6'h00, 16'h0000, 16'h1111},
    '{1'b1, 6'h05, 1'b0, 6'h00, 16'h0000, 16'h5a05},
    '{1'b1, 6'h0c, 1'b0, 6'h00, 16'h0000, 16'h5a0c},
    // bank 2 takes spare row 3 and the bank 1 word goes home
    '{1'b1, 6'h02, 1'b1, 6'h0e, 16'h2222, 16'h5a02},
    '{1'b1, 6'h0d, 1'b0, 6'h00, 16'h0000, 16'h1111},
    '{1'b1, 6'h0e, 1'b0, 6'h00, 16'h0000, 16'h2222},
    '{1'b1, 6'h02, 1'b0, 6'h00, 16'h0000, 16'h5a02},
    // write-only to a row held in the spare bank
    '{1'b0, 6'h00, 1'b1, 6'h0e, 16'h3333, 16'h0000},
    '{1'b1, 6'h0e, 1'b0, 6'h00, 16'h0000, 16'h3333},
    // spare read together with a home write in the same bank
    '{1'b1, 6'h0e, 1'b1, 6'h06, 16'h4444, 16'h3333},
    '{1'b1, 6'h06, 1'b0, 6'h00, 16'h0000, 16'h4444},
    // read and write of one address return the old word
    '{1'b1, 6'h21, 1'b1, 6'h21, 16'h5555, 16'h5a21},
    '{1'b1, 6'h21, 1'b0, 6'h00, 16'h0000, 16'h5555},
    '{1'b1, 6'h0e, 1'b1, 6'h0e, 16'h6666, 16'h3333},
    '{1'b1, 6'h0e, 1'b0, 6'h00, 16'h0000, 16'h6666},
    // different banks in one request
    '{1'b1, 6'h10, 1'b1, 6'h11, 16'h7777, 16'h5a10},
    '{1'b1, 6'h11, 1'b0, 6'h00, 16'h0000, 16'h7777},
    // bank 3 takes spare row 8 and evicts the bank 1 word
    '{1'b1, 6'h03, 1'b1, 6'h23, 16'h8888, 16'h5a03},
    '{1'b1, 6'h21, 1'b0, 6'h00, 16'h0000, 16'h5555},
    '{1'b1, 6'h23, 1'b0, 6'h00, 16'h0000, 16'h8888},
    // a home write followed by a same-address conflict on it
    '{1'b0, 6'h00, 1'b1, 6'h3f, 16'h9999, 16'h0000},
    '{1'b1, 6'h3f, 1'b1, 6'h3f, 16'haaaa, 16'h9999},
    '{1'b1, 6'h3f, 1'b0, 6'h00, 16'h0000, 16'haaaa}
  };

`endif

//--- test/mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_tb import mem_pkg::*; ();

  localparam int NUM_ADDR = 1 << ADDR_W;
  localparam int RAND_OPS = 300;

  typedef struct packed {
    logic              rd;
    logic [ADDR_W-1:0] rd_addr;
    logic              wr;
    logic [ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;
    logic [DATA_W-1:0] exp_data;
  } table_entry_t;

  `include "mem_tb_table.svh"

  // fill and readback count as one entry per address each
  localparam int TIMEOUT_CYCLES = 20 * (2 * NUM_ADDR + TABLE_LEN + RAND_OPS) + 50;

  logic      clk;
  logic      rst;
  logic      in_valid;
  mem_req_t  in_req;
  logic      in_ready;
  logic      out_valid;
  mem_resp_t out_resp;
  logic      out_ready;

  logic [DATA_W-1:0] ref_mem [NUM_ADDR];
  logic [DATA_W-1:0] exp_q [$];
  string             name_q [$];
  logic [31:0]       lfsr_state;
  logic              rand_ready;
  int                cycles;

  mem_top mem_top_inst (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_resp  (out_resp),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      stop_run($sformatf("FAILED %s: expected %h, actual %h", name, exp_val, act_val));
    end
  endtask

  // taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  function automatic mem_req_t make_req(input logic rd, input logic [ADDR_W-1:0] rd_addr,
                                        input logic wr, input logic [ADDR_W-1:0] wr_addr,
                                        input logic [DATA_W-1:0] wr_data);
    mem_req_t r;
    r.rd      = rd;
    r.rd_addr = rd_addr;
    r.wr      = wr;
    r.wr_addr = wr_addr;
    r.wr_data = wr_data;
    return r;
  endfunction

  // every address bit shows up in the word, so aliased rows are caught
  function automatic logic [DATA_W-1:0] fill_word(input int a);
    return 16'h5a00 | DATA_W'(a);
  endfunction

  // one clock step with the inputs changing 1 ns after the edge
  task automatic next_cycle(output logic accepted);
    logic [31:0] r;
    @(posedge clk);
    accepted = in_valid && in_ready;
    #1;
    if (rand_ready) begin
      take_bits(1, r);
      out_ready = r[0];
    end
  endtask

  task automatic idle_cycles(input int n);
    logic accepted;
    for (int i = 0; i < n; i++) begin
      next_cycle(accepted);
    end
  endtask

  // the model runs in request order, which is also the response order
  task automatic send_req(input string name, input mem_req_t r,
                          input logic [DATA_W-1:0] exp_val);
    logic accepted;
    if (r.rd) begin
      exp_q.push_back(exp_val);
      name_q.push_back(name);
    end
    if (r.wr) begin
      ref_mem[r.wr_addr] = r.wr_data;
    end
    in_valid = 1'b1;
    in_req   = r;
    do begin
      next_cycle(accepted);
    end while (!accepted);
    in_valid = 1'b0;
  endtask

  always @(posedge clk) begin
    if (!rst && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        stop_run("a response arrived that no read request asked for");
      end else begin
        check_value(name_q.pop_front(), 32'(exp_q.pop_front()), 32'(out_resp.data));
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT_CYCLES) begin
      stop_run($sformatf("timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  initial begin
    mem_req_t     r;
    table_entry_t e;
    logic [31:0]  v_rd;
    logic [31:0]  v_rda;
    logic [31:0]  v_wr;
    logic [31:0]  v_wra;
    logic [31:0]  v_data;
    logic [31:0]  v_gap;

    rst        = 1'b1;
    in_valid   = 1'b0;
    in_req     = '0;
    out_ready  = 1'b1;
    rand_ready = 1'b0;
    lfsr_state = 32'h7d9e;
    cycles     = 0;

    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    check_value("reset out_valid", 32'h0, 32'(out_valid));
    check_value("reset in_ready", 32'h1, 32'(in_ready));

    for (int a = 0; a < NUM_ADDR; a++) begin
      send_req($sformatf("fill %0d", a),
               make_req(1'b0, '0, 1'b1, ADDR_W'(a), fill_word(a)), '0);
    end
    for (int a = 0; a < NUM_ADDR; a++) begin
      send_req($sformatf("readback %0d", a),
               make_req(1'b1, ADDR_W'(a), 1'b0, '0, '0), ref_mem[a]);
    end

    for (int i = 0; i < TABLE_LEN; i++) begin
      e = STIM_TABLE[i];
      if (e.rd) begin
        check_value($sformatf("table %0d model", i), 32'(e.exp_data),
                    32'(ref_mem[e.rd_addr]));
      end
      send_req($sformatf("table %0d", i),
               make_req(e.rd, e.rd_addr, e.wr, e.wr_addr, e.wr_data), e.exp_data);
    end

    rand_ready = 1'b1;
    for (int i = 0; i < RAND_OPS; i++) begin
      take_bits(1, v_rd);
      take_bits(ADDR_W, v_rda);
      take_bits(1, v_wr);
      take_bits(ADDR_W, v_wra);
      take_bits(DATA_W, v_data);
      take_bits(2, v_gap);
      r = make_req(v_rd[0], v_rda[ADDR_W-1:0], v_wr[0], v_wra[ADDR_W-1:0],
                   v_data[DATA_W-1:0]);
      send_req($sformatf("random %0d", i), r, ref_mem[r.rd_addr]);
      idle_cycles(int'(v_gap[1:0]));
    end

    // drain the queue and then give extra responses a chance to show up
    rand_ready = 1'b0;
    out_ready  = 1'b1;
    while (exp_q.size() != 0) begin
      idle_cycles(1);
    end
    idle_cycles(10);

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+test
source/mem_pkg.sv
source/stream_fifo.sv
source/bank_array.sv
source/remap_table.sv
source/access_ctrl.sv
source/mem_top.sv
test/mem_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= mem_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
